// File: files.f
rtl/mips_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/hilo_unit.sv
rtl/reg_file.sv
rtl/exec_core.sv
bench/exec_core_tb.sv
+incdir+bench

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only --timing -Wall
TOP        = exec_core_tb
FILELIST   = files.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/exec_cases.svh
    task automatic load_cases();
        // valid, instr, pc, mem_rdata | expected wb_en, wb_addr, wb_data, taken, target,
        // mem_en, mem_write, mem_addr, mem_wdata, spec_inst, undefined_inst
        // idle cycles with lw r5, beq r0,r0 and addiu r18 must do nothing
        add_case(0, 'h8c050000, 'h00400000, 'h12345678, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(0, 'h10000004, 'h00400004, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(0, 'h24120055, 'h00400008, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // addiu r1 -5, ori r2, andi r3, lui r4, addiu into r0
        add_case(1, 'h2401fffb, 'h0040000c, 0, 1, 1, 'hfffffffb, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h34028001, 'h00400010, 0, 1, 2, 'h00008001, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h3023ff00, 'h00400014, 0, 1, 3, 'h0000ff00, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h3c041234, 'h00400018, 0, 1, 4, 'h12340000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h24000007, 'h0040001c, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // addu, subu, slt vs sltu, nor, sll 4, srav by r10
        add_case(1, 'h00822821, 'h00400020, 0, 1, 5, 'h12348001, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00443023, 'h00400024, 0, 1, 6, 'hedcc8001, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h0022382a, 'h00400028, 0, 1, 7, 'h00000001, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h0022402b, 'h0040002c, 0, 1, 8, 'h00000000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00624827, 'h00400030, 0, 1, 9, 'hffff00fe, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00025100, 'h00400034, 0, 1, 10, 'h00080010, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h01465807, 'h00400038, 0, 1, 11, 'hffffedcc, 0, 0, 0, 0, 0, 0, 0, 0);
        // mult -5 * 0x12340000, mfhi, mflo, mthi r5, mfhi
        add_case(1, 'h00240018, 'h0040003c, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00006010, 'h00400040, 0, 1, 12, 'hffffffff, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00006812, 'h00400044, 0, 1, 13, 'ha4fc0000, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00a00011, 'h00400048, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00007010, 'h0040004c, 0, 1, 14, 'h12348001, 0, 0, 0, 0, 0, 0, 0, 0);
        // beq taken / not, bne taken / not
        add_case(1, 'h10420008, 'h00400050, 0, 0, 0, 0, 1, 'h00400074, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h1022fffc, 'h00400054, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h1422fffc, 'h00400058, 0, 0, 0, 0, 1, 'h0040004c, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h14630010, 'h0040005c, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // bltzal links either way
        add_case(1, 'h04300020, 'h00400060, 0, 1, link_reg, 'h00400068, 1, 'h004000e4,
                 0, 0, 0, 0, 0, 0);
        add_case(1, 'h04500020, 'h00400064, 0, 1, link_reg, 'h0040006c, 0, 0,
                 0, 0, 0, 0, 0, 0);
        // j, jal, jr r4, jalr r15 <- r5
        add_case(1, 'h08100040, 'h00400068, 0, 0, 0, 0, 1, 'h00400100, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h0c100080, 'h0040006c, 0, 1, link_reg, 'h00400074, 1, 'h00400200,
                 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00800008, 'h00400070, 0, 0, 0, 0, 1, 'h12340000, 0, 0, 0, 0, 0, 0);
        add_case(1, 'h00a07809, 'h00400074, 0, 1, 15, 'h0040007c, 1, 'h12348001,
                 0, 0, 0, 0, 0, 0);
        // lw r16 -8(r4), sw r16 4(r3)
        add_case(1, 'h8c90fff8, 'h00400078, 'hcafef00d, 1, 16, 'hcafef00d, 0, 0,
                 1, 0, 'h1233fff8, 0, 0, 0);
        add_case(1, 'hac700004, 'h0040007c, 0, 0, 0, 0, 0, 0,
                 1, 1, 'h0000ff04, 'hcafef00d, 0, 0);
        // syscall, break, mtc0, op 0x3f, div, lb, all-zero word
        add_case(1, 'h0000000c, 'h00400080, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add_case(1, 'h0000000d, 'h00400084, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add_case(1, 'h40826000, 'h00400088, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add_case(1, 'hfc000000, 'h0040008c, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        add_case(1, 'h0022001a, 'h00400090, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        add_case(1, 'h80110000, 'h00400094, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        add_case(1, 'h00000000, 'h00400098, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // r18 untouched by the idle addiu
        add_case(1, 'h02409821, 'h0040009c, 0, 1, 19, 'h00000000, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

// File: bench/exec_core_tb.sv
`default_nettype none

module exec_core_tb import mips_pkg::*; ();

    localparam int half_period  = 5;
    localparam int reset_cycles = 4;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rdata;
        logic        wb_en;
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;
        logic        taken;
        logic [31:0] target;
        logic        mem_en;
        logic        mem_write;
        logic [31:0] mem_addr;
        logic [31:0] wdata;
        logic        spec;
        logic        undef;
    } test_case_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] mem_rdata;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        mem_en;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        spec_inst;
    logic        undefined_inst;

    test_case_t cases[$];
    int         errors;
    int         failed_cases;
    int         cycles;
    int         cycle_limit;

    exec_core DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .mem_rdata      (mem_rdata),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .mem_en         (mem_en),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .spec_inst      (spec_inst),
        .undefined_inst (undefined_inst)
    );

    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // one table row in test_case_t field order
    task automatic add_case(input logic v, input logic [31:0] iw, input logic [31:0] p,
                            input logic [31:0] rd, input logic we, input logic [4:0] wa,
                            input logic [31:0] wd, input logic tk, input logic [31:0] tg,
                            input logic me, input logic mw, input logic [31:0] ma,
                            input logic [31:0] md, input logic sp, input logic ud);
        cases.push_back({v, iw, p, rd, we, wa, wd, tk, tg, me, mw, ma, md, sp, ud});
    endtask

    `include "exec_cases.svh"

    task automatic report_mismatch(input int idx, input string name, input logic [31:0] got,
                                   input logic [31:0] want, inout int bad);
        $display("[ERROR] %0t: case %0d %s is %h, expected %h", $time, idx, name, got, want);
        bad++;
    endtask

    task automatic check_case(input int idx, input test_case_t tc);
        int bad;
        bad = 0;
        if (wb_en !== tc.wb_en)
            report_mismatch(idx, "wb_en", 32'(wb_en), 32'(tc.wb_en), bad);
        if (tc.wb_en && wb_addr !== tc.wb_addr)
            report_mismatch(idx, "wb_addr", 32'(wb_addr), 32'(tc.wb_addr), bad);
        if (tc.wb_en && wb_data !== tc.wb_data)
            report_mismatch(idx, "wb_data", wb_data, tc.wb_data, bad);
        if (branch_taken !== tc.taken)
            report_mismatch(idx, "branch_taken", 32'(branch_taken), 32'(tc.taken), bad);
        if (tc.taken && branch_target !== tc.target)  // target only matters when taken
            report_mismatch(idx, "branch_target", branch_target, tc.target, bad);
        if (mem_en !== tc.mem_en)
            report_mismatch(idx, "mem_en", 32'(mem_en), 32'(tc.mem_en), bad);
        if (mem_write !== tc.mem_write)
            report_mismatch(idx, "mem_write", 32'(mem_write), 32'(tc.mem_write), bad);
        if (tc.mem_en && mem_addr !== tc.mem_addr)
            report_mismatch(idx, "mem_addr", mem_addr, tc.mem_addr, bad);
        if (tc.mem_write && mem_wdata !== tc.wdata)  // store data from rt
            report_mismatch(idx, "mem_wdata", mem_wdata, tc.wdata, bad);
        if (spec_inst !== tc.spec)
            report_mismatch(idx, "spec_inst", 32'(spec_inst), 32'(tc.spec), bad);
        if (undefined_inst !== tc.undef)
            report_mismatch(idx, "undefined_inst", 32'(undefined_inst), 32'(tc.undef), bad);
        if (bad == 0) begin
            $display("case %0d instr %h: pass", idx, tc.instr);
        end else begin
            $display("case %0d instr %h: %0d mismatches", idx, tc.instr, bad);
            failed_cases++;
        end
        errors += bad;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;  // held low through reset
        instr        = 32'b0;
        pc           = 32'b0;
        mem_rdata    = 32'b0;
        errors       = 0;
        failed_cases = 0;
        cycles       = 0;
        load_cases();
        cycle_limit = cases.size() + reset_cycles + 20;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < cases.size(); i++) begin
            @(negedge clk);
            instr_valid = cases[i].valid;
            instr       = cases[i].instr;
            pc          = cases[i].pc;
            mem_rdata   = cases[i].rdata;
            #(half_period - 1);  // just ahead of the write edge
            check_case(i, cases[i]);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        $display("%0d cases run, %0d passed, %0d failed, %0d mismatches", cases.size(),
                 cases.size() - failed_cases, failed_cases, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/exec_core.sv
`default_nettype none

module exec_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  instr_word_t instr,
    input  logic [31:0] pc,
    input  logic [31:0] mem_rdata,
    output logic        wb_en,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data,
    output logic        branch_taken,
    output logic [31:0] branch_target,
    output logic        mem_en,
    output logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        spec_inst,
    output logic        undefined_inst
);

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] ext_imm;
    logic [25:0] j_target;
    logic [4:0]  shamt;
    logic [4:0]  alu_op;
    logic        alu_sel_a;
    logic        alu_sel_b;
    logic        dec_mem_en;
    logic        mem_to_reg;
    logic        reg_wen;
    logic        hilo_write;
    logic        is_link;
    logic [3:0]  branch_type;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] alu_result;
    logic        taken;
    logic [31:0] link_addr;
    logic [31:0] hilo_value;

    instr_decoder u_decoder (
        .instr          (instr),
        .rs             (rs),
        .rt             (rt),
        .ext_imm        (ext_imm),
        .j_target       (j_target),
        .shamt          (shamt),
        .alu_op         (alu_op),
        .alu_sel_a      (alu_sel_a),
        .alu_sel_b      (alu_sel_b),
        .mem_en         (dec_mem_en),
        .mem_write      (mem_write),
        .mem_to_reg     (mem_to_reg),
        .reg_wen        (reg_wen),
        .hilo_write     (hilo_write),
        .is_link        (is_link),
        .branch_type    (branch_type),
        .reg_waddr      (wb_addr),
        .spec_inst      (spec_inst),
        .undefined_inst (undefined_inst)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rs),
        .raddr_b (rt),
        .waddr   (wb_addr),
        .wen     (wb_en),
        .wdata   (wb_data),
        .rdata_a (rs_value),
        .rdata_b (rt_value)
    );

    alu u_alu (
        .alu_op    (alu_op),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .ext_imm   (ext_imm),
        .shamt     (shamt),
        .alu_sel_a (alu_sel_a),
        .alu_sel_b (alu_sel_b),
        .result    (alu_result)
    );

    branch_unit u_branch (
        .branch_type (branch_type),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .pc          (pc),
        .ext_imm     (ext_imm),
        .j_target    (j_target),
        .taken       (taken),
        .target      (branch_target),
        .link_addr   (link_addr)
    );

    hilo_unit u_hilo (
        .clk        (clk),
        .rst_n      (rst_n),
        .write      (hilo_write && instr_valid),  // no state change on idle cycles
        .alu_op     (alu_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .read_value (hilo_value)
    );

    // write-back source, link first
    always_comb begin
        if (is_link)
            wb_data = link_addr;
        else if (mem_to_reg)
            wb_data = mem_rdata;
        else if (alu_op == aluop_mfhi || alu_op == aluop_mflo)
            wb_data = hilo_value;
        else
            wb_data = alu_result;
    end

    assign wb_en        = reg_wen && instr_valid && (wb_addr != 5'd0);
    assign mem_en       = dec_mem_en && instr_valid;
    assign branch_taken = taken && instr_valid;
    assign mem_addr     = alu_result;  // base + offset
    assign mem_wdata    = rt_value;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    input  logic [4:0]  waddr,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata_a = (raddr_a == 5'd0) ? 32'b0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'b0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: rtl/hilo_unit.sv
`default_nettype none

module hilo_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        write,
    input  logic [4:0]  alu_op,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    output logic [31:0] read_value
);

    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    logic [63:0] product;

    // low 64 bits of the sign-extended product give the signed result
    assign prod_s  = {{32{rs_value[31]}}, rs_value} * {{32{rt_value[31]}}, rt_value};
    assign prod_u  = {32'b0, rs_value} * {32'b0, rt_value};
    assign product = (alu_op == aluop_mult) ? prod_s : prod_u;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= 32'b0;
            lo <= 32'b0;
        end else if (write) begin
            case (alu_op)
                aluop_mult, aluop_multu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                aluop_mthi: hi <= rs_value;
                aluop_mtlo: lo <= rs_value;
                default: ;
            endcase
        end
    end

    assign read_value = (alu_op == aluop_mfhi) ? hi : lo;

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`default_nettype none

module branch_unit import mips_pkg::*; (
    input  logic [3:0]  branch_type,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  logic [31:0] pc,
    input  logic [31:0] ext_imm,
    input  logic [25:0] j_target,
    output logic        taken,
    output logic [31:0] target,
    output logic [31:0] link_addr
);

    logic [31:0] pc_plus4;
    logic [31:0] branch_addr;
    logic        rs_zero;

    assign pc_plus4    = pc + 32'd4;
    assign branch_addr = pc_plus4 + {ext_imm[29:0], 2'b00};
    assign link_addr   = pc + 32'd8;  // past the delay slot
    assign rs_zero     = (rs_value == 32'b0);

    always_comb begin
        taken  = 1'b0;
        target = branch_addr;
        case (branch_type)
            bt_j: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], j_target, 2'b00};  // stays in the 256 MB region
            end
            bt_jreg: begin
                taken  = 1'b1;
                target = rs_value;
            end
            bt_beq:  taken = (rs_value == rt_value);
            bt_bne:  taken = (rs_value != rt_value);
            bt_bgtz: taken = !rs_value[31] && !rs_zero;
            bt_blez: taken = rs_value[31] || rs_zero;
            bt_bgez: taken = !rs_value[31];
            bt_bltz: taken = rs_value[31];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu import mips_pkg::*; (
    input  logic [4:0]  alu_op,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  logic [31:0] ext_imm,
    input  logic [4:0]  shamt,
    input  logic        alu_sel_a,
    input  logic        alu_sel_b,
    output logic [31:0] result
);

    logic [31:0] a;
    logic [31:0] b;

    assign a = alu_sel_a ? rt_value : rs_value;  // rt for fixed shifts
    assign b = alu_sel_b ? ext_imm : rt_value;

    always_comb begin
        case (alu_op)
            aluop_and:  result = a & b;
            aluop_or:   result = a | b;
            aluop_xor:  result = a ^ b;
            aluop_nor:  result = ~(a | b);
            aluop_slt:  result = {31'b0, $signed(a) < $signed(b)};
            aluop_sltu: result = {31'b0, a < b};
            // no overflow trap, add/sub wrap
            aluop_add, aluop_addu: result = a + b;
            aluop_sub, aluop_subu: result = a - b;
            aluop_sll:  result = a << shamt;
            aluop_srl:  result = a >> shamt;
            aluop_sra:  result = $signed(a) >>> shamt;
            aluop_sllv: result = b << a[4:0];  // amount from rs
            aluop_srlv: result = b >> a[4:0];
            aluop_srav: result = $signed(b) >>> a[4:0];
            aluop_lui:  result = {b[15:0], 16'b0};
            default:    result = 32'b0;  // hilo, cp0 and nop
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

module instr_decoder import mips_pkg::*; (
    input  instr_word_t instr,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [31:0] ext_imm,
    output logic [25:0] j_target,
    output logic [4:0]  shamt,
    output logic [4:0]  alu_op,
    output logic        alu_sel_a,
    output logic        alu_sel_b,
    output logic        mem_en,
    output logic        mem_write,
    output logic        mem_to_reg,
    output logic        reg_wen,
    output logic        hilo_write,
    output logic        is_link,
    output logic [3:0]  branch_type,
    output logic [4:0]  reg_waddr,
    output logic        spec_inst,
    output logic        undefined_inst
);

    logic zero_ext;  // logic-immediate ops

    assign rs       = instr.r.rs;
    assign rt       = instr.r.rt;
    assign shamt    = instr.r.shamt;
    assign j_target = instr.j.target;

    assign zero_ext = (instr.i.op == op_andi) || (instr.i.op == op_ori) ||
                      (instr.i.op == op_xori);
    assign ext_imm  = zero_ext ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        alu_op         = aluop_nop;
        alu_sel_a      = 1'b0;
        alu_sel_b      = 1'b0;
        mem_en         = 1'b0;
        mem_write      = 1'b0;
        mem_to_reg     = 1'b0;
        reg_wen        = 1'b0;
        hilo_write     = 1'b0;
        is_link        = 1'b0;
        branch_type    = bt_nop;
        reg_waddr      = instr.r.rd;
        spec_inst      = 1'b0;
        undefined_inst = 1'b0;
        if (instr != 32'b0) begin  // all-zero word stays a nop
            case (instr.r.op)
                op_rtype: begin
                    reg_wen = 1'b1;  // most funct codes write rd
                    case (instr.r.funct)
                        fun_and:  alu_op = aluop_and;
                        fun_or:   alu_op = aluop_or;
                        fun_xor:  alu_op = aluop_xor;
                        fun_nor:  alu_op = aluop_nor;
                        fun_slt:  alu_op = aluop_slt;
                        fun_sltu: alu_op = aluop_sltu;
                        fun_add:  alu_op = aluop_add;
                        fun_addu: alu_op = aluop_addu;
                        fun_sub:  alu_op = aluop_sub;
                        fun_subu: alu_op = aluop_subu;
                        fun_sllv: alu_op = aluop_sllv;
                        fun_srlv: alu_op = aluop_srlv;
                        fun_srav: alu_op = aluop_srav;
                        fun_mfhi: alu_op = aluop_mfhi;
                        fun_mflo: alu_op = aluop_mflo;
                        fun_sll, fun_srl, fun_sra: begin
                            alu_sel_a = 1'b1;  // shift rt by shamt
                            alu_op    = (instr.r.funct == fun_sll) ? aluop_sll :
                                        (instr.r.funct == fun_srl) ? aluop_srl : aluop_sra;
                        end
                        fun_mult, fun_multu, fun_mthi, fun_mtlo: begin
                            reg_wen    = 1'b0;
                            hilo_write = 1'b1;
                            alu_op     = (instr.r.funct == fun_mult)  ? aluop_mult  :
                                         (instr.r.funct == fun_multu) ? aluop_multu :
                                         (instr.r.funct == fun_mthi)  ? aluop_mthi  : aluop_mtlo;
                        end
                        fun_jr: begin
                            reg_wen     = 1'b0;
                            branch_type = bt_jreg;
                        end
                        fun_jalr: begin
                            branch_type = bt_jreg;
                            is_link     = 1'b1;  // pc+8 into rd
                        end
                        fun_syscall, fun_break: begin
                            reg_wen   = 1'b0;
                            spec_inst = 1'b1;
                        end
                        default: begin  // div, divu and unknown funct
                            reg_wen        = 1'b0;
                            undefined_inst = 1'b1;
                        end
                    endcase
                end
                op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                    reg_wen   = 1'b1;
                    alu_sel_b = 1'b1;
                    reg_waddr = instr.i.rt;
                    case (instr.i.op)
                        op_addi:  alu_op = aluop_add;
                        op_addiu: alu_op = aluop_addu;
                        op_slti:  alu_op = aluop_slt;
                        op_sltiu: alu_op = aluop_sltu;
                        op_andi:  alu_op = aluop_and;
                        op_ori:   alu_op = aluop_or;
                        op_xori:  alu_op = aluop_xor;
                        default:  alu_op = aluop_lui;
                    endcase
                end
                op_lw: begin
                    alu_op     = aluop_addu;  // base + offset
                    alu_sel_b  = 1'b1;
                    mem_en     = 1'b1;
                    mem_to_reg = 1'b1;
                    reg_wen    = 1'b1;
                    reg_waddr  = instr.i.rt;
                end
                op_sw: begin
                    alu_op    = aluop_addu;
                    alu_sel_b = 1'b1;
                    mem_en    = 1'b1;
                    mem_write = 1'b1;
                end
                op_j:    branch_type = bt_j;
                op_jal: begin
                    branch_type = bt_j;
                    is_link     = 1'b1;
                    reg_wen     = 1'b1;
                    reg_waddr   = link_reg;
                end
                op_beq:  branch_type = bt_beq;
                op_bne:  branch_type = bt_bne;
                op_bgtz: branch_type = bt_bgtz;
                op_blez: branch_type = bt_blez;
                op_regimm: begin
                    case (instr.i.rt)
                        rt_bgez: branch_type = bt_bgez;
                        rt_bltz: branch_type = bt_bltz;
                        rt_bgezal, rt_bltzal: begin
                            branch_type = (instr.i.rt == rt_bgezal) ? bt_bgez : bt_bltz;
                            is_link     = 1'b1;  // link even when not taken
                            reg_wen     = 1'b1;
                            reg_waddr   = link_reg;
                        end
                        default: undefined_inst = 1'b1;
                    endcase
                end
                op_cop0: begin
                    spec_inst = 1'b1;
                    case (instr.r.rs)
                        rs_mfc0: begin
                            alu_op  = aluop_mfc0;
                            reg_wen = 1'b1;
                        end
                        rs_mtc0: alu_op = aluop_mtc0;
                        default: ;
                    endcase
                end
                default: undefined_inst = 1'b1;  // byte/half memory ops land here too
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_rtype  = 6'b000000;
    localparam logic [5:0] op_regimm = 6'b000001;  // bgez, bltz and the linking forms
    localparam logic [5:0] op_j      = 6'b000010;
    localparam logic [5:0] op_jal    = 6'b000011;
    localparam logic [5:0] op_beq    = 6'b000100;
    localparam logic [5:0] op_bne    = 6'b000101;
    localparam logic [5:0] op_blez   = 6'b000110;
    localparam logic [5:0] op_bgtz   = 6'b000111;
    localparam logic [5:0] op_addi   = 6'b001000;
    localparam logic [5:0] op_addiu  = 6'b001001;
    localparam logic [5:0] op_slti   = 6'b001010;
    localparam logic [5:0] op_sltiu  = 6'b001011;
    localparam logic [5:0] op_andi   = 6'b001100;
    localparam logic [5:0] op_ori    = 6'b001101;
    localparam logic [5:0] op_xori   = 6'b001110;
    localparam logic [5:0] op_lui    = 6'b001111;
    localparam logic [5:0] op_cop0   = 6'b010000;
    localparam logic [5:0] op_lw     = 6'b100011;
    localparam logic [5:0] op_sw     = 6'b101011;

    // funct field of r-type words
    localparam logic [5:0] fun_sll     = 6'b000000;
    localparam logic [5:0] fun_srl     = 6'b000010;
    localparam logic [5:0] fun_sra     = 6'b000011;
    localparam logic [5:0] fun_sllv    = 6'b000100;
    localparam logic [5:0] fun_srlv    = 6'b000110;
    localparam logic [5:0] fun_srav    = 6'b000111;
    localparam logic [5:0] fun_jr      = 6'b001000;
    localparam logic [5:0] fun_jalr    = 6'b001001;
    localparam logic [5:0] fun_syscall = 6'b001100;
    localparam logic [5:0] fun_break   = 6'b001101;
    localparam logic [5:0] fun_mfhi    = 6'b010000;
    localparam logic [5:0] fun_mthi    = 6'b010001;
    localparam logic [5:0] fun_mflo    = 6'b010010;
    localparam logic [5:0] fun_mtlo    = 6'b010011;
    localparam logic [5:0] fun_mult    = 6'b011000;
    localparam logic [5:0] fun_multu   = 6'b011001;
    localparam logic [5:0] fun_add     = 6'b100000;
    localparam logic [5:0] fun_addu    = 6'b100001;
    localparam logic [5:0] fun_sub     = 6'b100010;
    localparam logic [5:0] fun_subu    = 6'b100011;
    localparam logic [5:0] fun_and     = 6'b100100;
    localparam logic [5:0] fun_or      = 6'b100101;
    localparam logic [5:0] fun_xor     = 6'b100110;
    localparam logic [5:0] fun_nor     = 6'b100111;
    localparam logic [5:0] fun_slt     = 6'b101010;
    localparam logic [5:0] fun_sltu    = 6'b101011;

    localparam logic [4:0] rt_bltz   = 5'b00000;
    localparam logic [4:0] rt_bgez   = 5'b00001;
    localparam logic [4:0] rt_bltzal = 5'b10000;
    localparam logic [4:0] rt_bgezal = 5'b10001;
    localparam logic [4:0] rs_mfc0   = 5'b00000;
    localparam logic [4:0] rs_mtc0   = 5'b00100;

    localparam logic [4:0] link_reg = 5'd31;

    localparam logic [4:0] aluop_nop   = 5'd0;
    localparam logic [4:0] aluop_and   = 5'd1;
    localparam logic [4:0] aluop_or    = 5'd2;
    localparam logic [4:0] aluop_xor   = 5'd3;
    localparam logic [4:0] aluop_nor   = 5'd4;
    localparam logic [4:0] aluop_slt   = 5'd5;
    localparam logic [4:0] aluop_sltu  = 5'd6;
    localparam logic [4:0] aluop_add   = 5'd7;
    localparam logic [4:0] aluop_addu  = 5'd8;
    localparam logic [4:0] aluop_sub   = 5'd9;
    localparam logic [4:0] aluop_subu  = 5'd10;
    localparam logic [4:0] aluop_sll   = 5'd11;
    localparam logic [4:0] aluop_sllv  = 5'd12;
    localparam logic [4:0] aluop_srl   = 5'd13;
    localparam logic [4:0] aluop_srlv  = 5'd14;
    localparam logic [4:0] aluop_sra   = 5'd15;
    localparam logic [4:0] aluop_srav  = 5'd16;
    localparam logic [4:0] aluop_lui   = 5'd17;
    localparam logic [4:0] aluop_mult  = 5'd18;
    localparam logic [4:0] aluop_multu = 5'd19;
    localparam logic [4:0] aluop_mfhi  = 5'd20;
    localparam logic [4:0] aluop_mflo  = 5'd21;
    localparam logic [4:0] aluop_mthi  = 5'd22;
    localparam logic [4:0] aluop_mtlo  = 5'd23;
    localparam logic [4:0] aluop_mfc0  = 5'd24;
    localparam logic [4:0] aluop_mtc0  = 5'd25;

    localparam logic [3:0] bt_nop  = 4'd0;
    localparam logic [3:0] bt_j    = 4'd1;
    localparam logic [3:0] bt_jreg = 4'd2;  // jr and jalr
    localparam logic [3:0] bt_beq  = 4'd3;
    localparam logic [3:0] bt_bne  = 4'd4;
    localparam logic [3:0] bt_bgtz = 4'd5;
    localparam logic [3:0] bt_blez = 4'd6;
    localparam logic [3:0] bt_bgez = 4'd7;
    localparam logic [3:0] bt_bltz = 4'd8;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_form_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_form_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_form_t;

    // one fetched word, three field layouts
    typedef union packed {
        r_form_t r;
        i_form_t i;
        j_form_t j;
    } instr_word_t;

endpackage

`default_nettype wire
